// ==== build.f ====
+incdir+testbench
rtl/ray_pkg.sv
rtl/ps2_receiver.sv
rtl/key_decoder.sv
rtl/camera_control.sv
rtl/control_top.sv
testbench/tb_control_top.sv

// ==== rtl/camera_control.sv ====
`timescale 1ns/10ps

module camera_control (
  input  logic                 sys_clk,
  input  logic                 sys_rst,
  input  ray_pkg::key_action_e action,
  input  logic                 action_valid,
  output ray_pkg::vec3_t       pos,
  output ray_pkg::vec3_t       dir,
  output logic [2:0]           fractal_sel,
  output logic                 toggle_hue,
  output logic                 toggle_dither,
  output logic                 toggle_texture
);

  logic fractal_last;

  // per-field sums wrap at 16 bits
  function automatic ray_pkg::vec3_t vec_add(input ray_pkg::vec3_t a,
                                             input ray_pkg::vec3_t b);
    ray_pkg::vec3_t r;
    r.x = a.x + b.x;
    r.y = a.y + b.y;
    r.z = a.z + b.z;
    return r;
  endfunction

  function automatic ray_pkg::vec3_t vec_sub(input ray_pkg::vec3_t a,
                                             input ray_pkg::vec3_t b);
    ray_pkg::vec3_t r;
    r.x = a.x - b.x;
    r.y = a.y - b.y;
    r.z = a.z - b.z;
    return r;
  endfunction

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      pos <= ray_pkg::RESET_POS;
    end else if (action_valid) begin
      case (action)
        ray_pkg::ACT_FORWARD: pos <= vec_add(pos, dir);
        ray_pkg::ACT_BACK:    pos <= vec_sub(pos, dir);
        ray_pkg::ACT_RISE:    pos.y <= pos.y + ray_pkg::RISE_STEP;
        ray_pkg::ACT_SINK:    pos.y <= pos.y - ray_pkg::RISE_STEP;
        default: begin
          pos <= pos;
        end
      endcase
    end
  end

  // quarter turns about the y axis
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      dir <= ray_pkg::RESET_DIR;
    end else if (action_valid) begin
      case (action)
        ray_pkg::ACT_TURN_LEFT: begin
          dir.x <= dir.z;
          dir.z <= -dir.x;
        end
        ray_pkg::ACT_TURN_RIGHT: begin
          dir.x <= -dir.z;
          dir.z <= dir.x;
        end
        default: begin
          dir <= dir;
        end
      endcase
    end
  end

  assign fractal_last = (fractal_sel == 3'(ray_pkg::FRACTAL_COUNT - 1));

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      fractal_sel <= '0;
    end else if (action_valid && action == ray_pkg::ACT_FRACTAL_NEXT) begin
      if (fractal_last) begin
        fractal_sel <= '0;
      end else begin
        fractal_sel <= fractal_sel + 1'b1;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      toggle_hue     <= 1'b0;
      toggle_dither  <= 1'b0;
      toggle_texture <= 1'b0;
    end else if (action_valid) begin
      case (action)
        ray_pkg::ACT_TOGGLE_HUE:     toggle_hue     <= !toggle_hue;
        ray_pkg::ACT_TOGGLE_DITHER:  toggle_dither  <= !toggle_dither;
        ray_pkg::ACT_TOGGLE_TEXTURE: toggle_texture <= !toggle_texture;
        default: begin
          toggle_hue <= toggle_hue;
        end
      endcase
    end
  end

  // turns only swap and negate, so dir stays on one axis
  a_dir_one_axis: assert property (
    @(posedge sys_clk) disable iff (sys_rst)
    $onehot({dir.x != 16'sh0000, dir.y != 16'sh0000, dir.z != 16'sh0000})
  );

  a_fractal_range: assert property (
    @(posedge sys_clk) disable iff (sys_rst)
    fractal_sel < 3'(ray_pkg::FRACTAL_COUNT)
  );

endmodule

// ==== rtl/control_top.sv ====
`timescale 1ns/10ps

module control_top (
  input  logic            sys_clk,
  input  logic            sys_rst,
  input  logic            ps2_clk,
  input  logic            ps2_data,
  output ray_pkg::coord_t pos_x,
  output ray_pkg::coord_t pos_y,
  output ray_pkg::coord_t pos_z,
  output ray_pkg::coord_t dir_x,
  output ray_pkg::coord_t dir_y,
  output ray_pkg::coord_t dir_z,
  output logic [2:0]      fractal_sel,
  output logic            toggle_hue,
  output logic            toggle_dither,
  output logic            toggle_texture,
  output logic            frame_error
);

  logic [7:0]           code;
  logic                 code_valid;
  ray_pkg::key_action_e action;
  logic                 action_valid;
  ray_pkg::vec3_t       pos;
  ray_pkg::vec3_t       dir;

  ps2_receiver i_ps2_receiver (
    .sys_clk     (sys_clk),
    .sys_rst     (sys_rst),
    .ps2_clk     (ps2_clk),
    .ps2_data    (ps2_data),
    .code        (code),
    .code_valid  (code_valid),
    .frame_error (frame_error)
  );

  key_decoder i_key_decoder (
    .sys_clk      (sys_clk),
    .sys_rst      (sys_rst),
    .code         (code),
    .code_valid   (code_valid),
    .action       (action),
    .action_valid (action_valid)
  );

  camera_control i_camera_control (
    .sys_clk        (sys_clk),
    .sys_rst        (sys_rst),
    .action         (action),
    .action_valid   (action_valid),
    .pos            (pos),
    .dir            (dir),
    .fractal_sel    (fractal_sel),
    .toggle_hue     (toggle_hue),
    .toggle_dither  (toggle_dither),
    .toggle_texture (toggle_texture)
  );

  // flat pins for the renderer side
  assign pos_x = pos.x;
  assign pos_y = pos.y;
  assign pos_z = pos.z;
  assign dir_x = dir.x;
  assign dir_y = dir.y;
  assign dir_z = dir.z;

endmodule

// ==== rtl/key_decoder.sv ====
`timescale 1ns/10ps

module key_decoder (
  input  logic                 sys_clk,
  input  logic                 sys_rst,
  input  logic [7:0]           code,
  input  logic                 code_valid,
  output ray_pkg::key_action_e action,
  output logic                 action_valid
);

  ray_pkg::decode_state_e state;
  ray_pkg::decode_state_e state_next;
  ray_pkg::key_action_e   hit_action;
  logic                   hit;

  always_comb begin
    state_next = state;
    hit        = 1'b0;
    hit_action = ray_pkg::ACT_FORWARD;
    if (code_valid) begin
      state_next = ray_pkg::ST_IDLE;
      case (state)
        ray_pkg::ST_IDLE: begin
          if (code == ray_pkg::SC_EXT) begin
            state_next = ray_pkg::ST_EXTENDED;
          end else if (code == ray_pkg::SC_BREAK) begin
            state_next = ray_pkg::ST_BREAK;
          end else begin
            hit = 1'b1;
            case (code)
              ray_pkg::SC_W: hit_action = ray_pkg::ACT_FORWARD;
              ray_pkg::SC_S: hit_action = ray_pkg::ACT_BACK;
              ray_pkg::SC_A: hit_action = ray_pkg::ACT_TURN_LEFT;
              ray_pkg::SC_D: hit_action = ray_pkg::ACT_TURN_RIGHT;
              ray_pkg::SC_F: hit_action = ray_pkg::ACT_FRACTAL_NEXT;
              ray_pkg::SC_H: hit_action = ray_pkg::ACT_TOGGLE_HUE;
              ray_pkg::SC_J: hit_action = ray_pkg::ACT_TOGGLE_DITHER;
              ray_pkg::SC_T: hit_action = ray_pkg::ACT_TOGGLE_TEXTURE;
              default:       hit = 1'b0;
            endcase
          end
        end
        ray_pkg::ST_EXTENDED: begin
          if (code == ray_pkg::SC_BREAK) begin
            state_next = ray_pkg::ST_EXT_BREAK;
          end else if (code == ray_pkg::SC_EXT) begin
            state_next = ray_pkg::ST_EXTENDED;
          end else if (code == ray_pkg::SC_UP) begin
            hit        = 1'b1;
            hit_action = ray_pkg::ACT_RISE;
          end else if (code == ray_pkg::SC_DOWN) begin
            hit        = 1'b1;
            hit_action = ray_pkg::ACT_SINK;
          end
        end
        // byte after F0 is a release, nothing to do
        default: begin
          state_next = ray_pkg::ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      state        <= ray_pkg::ST_IDLE;
      action_valid <= 1'b0;
    end else begin
      state        <= state_next;
      action_valid <= hit;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (hit) begin
      action <= hit_action;
    end
  end

  // released keys never act
  a_action_after_code: assert property (
    @(posedge sys_clk) disable iff (sys_rst)
    action_valid |-> $past(code_valid) &&
      ($past(state) == ray_pkg::ST_IDLE || $past(state) == ray_pkg::ST_EXTENDED)
  );

endmodule

// ==== rtl/ps2_receiver.sv ====
`timescale 1ns/10ps

module ps2_receiver (
  input  logic       sys_clk,
  input  logic       sys_rst,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  output logic [7:0] code,
  output logic       code_valid,
  output logic       frame_error
);

  logic [1:0] clk_sync;
  logic [1:0] data_sync;
  logic       clk_prev;
  logic       clk_fall;

  // bits received so far, newest at the top
  logic [ray_pkg::PS2_FRAME_BITS-2:0] shift_reg;
  logic [ray_pkg::PS2_FRAME_BITS-1:0] frame;
  logic [ray_pkg::PS2_BIT_CNT_W-1:0]  bit_cnt;
  logic [ray_pkg::PS2_IDLE_W-1:0]     idle_cnt;
  logic                               last_bit;
  logic                               frame_ok;
  logic                               idle_expired;

  // lines idle high, so the clock chain resets to 1
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      clk_sync <= 2'b11;
      clk_prev <= 1'b1;
    end else begin
      clk_sync <= {clk_sync[0], ps2_clk};
      clk_prev <= clk_sync[1];
    end
  end

  always_ff @(posedge sys_clk) begin
    data_sync <= {data_sync[0], ps2_data};
  end

  assign clk_fall = clk_prev && !clk_sync[1];

  // frame as it stands once the current bit is shifted in
  assign frame    = {data_sync[1], shift_reg};
  assign last_bit = (bit_cnt == ray_pkg::PS2_BIT_CNT_W'(ray_pkg::PS2_FRAME_BITS - 1));

  // start 0, odd parity over data and parity bit, stop 1
  assign frame_ok = !frame[0] && (^frame[9:1]) && frame[10];

  assign idle_expired = (idle_cnt == ray_pkg::PS2_IDLE_W'(ray_pkg::PS2_TIMEOUT_CYCLES - 1));

  always_ff @(posedge sys_clk) begin
    if (clk_fall) begin
      shift_reg <= frame[ray_pkg::PS2_FRAME_BITS-1:1];
    end
  end

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      bit_cnt  <= '0;
      idle_cnt <= '0;
    end else if (clk_fall) begin
      idle_cnt <= '0;
      if (last_bit) begin
        bit_cnt <= '0;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end else if (bit_cnt != '0) begin
      // keyboard went quiet mid frame, start over
      if (idle_expired) begin
        bit_cnt  <= '0;
        idle_cnt <= '0;
      end else begin
        idle_cnt <= idle_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      code_valid  <= 1'b0;
      frame_error <= 1'b0;
    end else begin
      code_valid  <= clk_fall && last_bit && frame_ok;
      frame_error <= clk_fall && last_bit && !frame_ok;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (clk_fall && last_bit) begin
      code <= frame[8:1];
    end
  end

  // one result per frame, a single-cycle pulse of one kind
  a_valid_error_excl: assert property (
    @(posedge sys_clk) disable iff (sys_rst)
    (code_valid || frame_error) |->
      $onehot({code_valid, frame_error}) ##1 !(code_valid || frame_error)
  );

endmodule

// ==== rtl/ray_pkg.sv ====
package ray_pkg;

  // Q8.8 signed fixed point
  typedef logic signed [15:0] coord_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
    coord_t z;
  } vec3_t;

  typedef enum logic [3:0] {
    ACT_FORWARD,
    ACT_BACK,
    ACT_TURN_LEFT,
    ACT_TURN_RIGHT,
    ACT_RISE,
    ACT_SINK,
    ACT_FRACTAL_NEXT,
    ACT_TOGGLE_HUE,
    ACT_TOGGLE_DITHER,
    ACT_TOGGLE_TEXTURE
  } key_action_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_EXTENDED,
    ST_BREAK,
    ST_EXT_BREAK
  } decode_state_e;

  // set-2 make codes
  localparam logic [7:0] SC_W     = 8'h1d;
  localparam logic [7:0] SC_S     = 8'h1b;
  localparam logic [7:0] SC_A     = 8'h1c;
  localparam logic [7:0] SC_D     = 8'h23;
  // arrows, only valid after the E0 prefix
  localparam logic [7:0] SC_UP    = 8'h75;
  localparam logic [7:0] SC_DOWN  = 8'h72;
  localparam logic [7:0] SC_F     = 8'h2b;
  localparam logic [7:0] SC_H     = 8'h33;
  localparam logic [7:0] SC_J     = 8'h3b;
  localparam logic [7:0] SC_T     = 8'h2c;
  localparam logic [7:0] SC_EXT   = 8'he0;
  localparam logic [7:0] SC_BREAK = 8'hf0;

  localparam coord_t RISE_STEP = 16'sh0100;

  // camera starts 4 units back, looking down +z
  localparam vec3_t RESET_POS = '{x: 16'sh0000, y: 16'sh0000, z: 16'shfc00};
  localparam vec3_t RESET_DIR = '{x: 16'sh0000, y: 16'sh0000, z: 16'sh0100};

  localparam int FRACTAL_COUNT = 5;

  localparam int PS2_FRAME_BITS     = 11;
  localparam int PS2_BIT_CNT_W      = 4;
  localparam int PS2_TIMEOUT_CYCLES = 2000;
  localparam int PS2_IDLE_W         = $clog2(PS2_TIMEOUT_CYCLES);

endpackage

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_control_top \
  -o sim_control_top
./obj_dir/sim_control_top | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q '\*\* PASS \*\*' sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"

// ==== testbench/tb_ps2_tasks.svh ====
`ifndef TB_PS2_TASKS_SVH
`define TB_PS2_TASKS_SVH

// sys_clk cycles per PS/2 clock phase
localparam int PS2_HALF_CYCLES = 16;

// returns 2 ns after a rising edge, where inputs are driven
task automatic wait_cycles(input int n);
  repeat (n) @(posedge sys_clk);
  #2;
endtask

// start, 8 data bits LSB first, odd parity, stop
task automatic send_ps2_byte(input logic [7:0] value, input logic bad_parity);
  logic [10:0] frame;
  frame = {1'b1, (~^value) ^ bad_parity, value, 1'b0};
  for (int i = 0; i < 11; i++) begin
    ps2_data = frame[i];
    wait_cycles(PS2_HALF_CYCLES);
    ps2_clk = 1'b0;
    wait_cycles(PS2_HALF_CYCLES);
    ps2_clk = 1'b1;
  end
endtask

task automatic check_vec3(input string name, input ray_pkg::vec3_t got,
                          input ray_pkg::vec3_t want);
  if (got !== want) begin
    $display("Mismatch %s: got %h expected %h at %0t", name, got, want, $time);
    mismatch_count++;
  end
endtask

task automatic check_fractal(input string name, input logic [2:0] got, input logic [2:0] want);
  if (got !== want) begin
    $display("Mismatch %s: got %h expected %h at %0t", name, got, want, $time);
    mismatch_count++;
  end
endtask

task automatic check_flag(input string name, input logic got, input logic want);
  if (got !== want) begin
    $display("Mismatch %s: got %h expected %h at %0t", name, got, want, $time);
    mismatch_count++;
  end
endtask

`endif

// ==== testbench/tb_control_top.sv ====
`timescale 1ns/10ps

module tb_control_top;

  typedef struct packed {
    logic [2:0][7:0]      bytes;
    logic [1:0]           count;
    logic                 corrupt;
    logic                 has_act;
    ray_pkg::key_action_e act;
  } entry_t;

  logic            sys_clk;
  logic            sys_rst;
  logic            ps2_clk;
  logic            ps2_data;
  ray_pkg::coord_t pos_x;
  ray_pkg::coord_t pos_y;
  ray_pkg::coord_t pos_z;
  ray_pkg::coord_t dir_x;
  ray_pkg::coord_t dir_y;
  ray_pkg::coord_t dir_z;
  logic [2:0]      fractal_sel;
  logic            toggle_hue;
  logic            toggle_dither;
  logic            toggle_texture;
  logic            frame_error;

  entry_t         stim[$];
  logic           table_ready = 1'b0;
  int             mismatch_count = 0;
  int             frame_err_seen = 0;
  int             corrupt_sent = 0;
  ray_pkg::vec3_t model_pos;
  ray_pkg::vec3_t model_dir;
  logic [2:0]     model_fractal;
  logic           model_hue;
  logic           model_dither;
  logic           model_texture;

  `include "tb_ps2_tasks.svh"

  control_top i_control_top (.*);

  initial begin
    sys_clk = 1'b0;
    forever #20 sys_clk = ~sys_clk;
  end

  always @(posedge sys_clk) begin
    if (!sys_rst && frame_error) begin
      frame_err_seen++;
    end
  end

  // budget of 3 bytes per entry, doubled
  initial begin
    longint limit_ns;
    wait (table_ready);
    limit_ns = longint'(stim.size()) * 3 * 11 * 32 * 40 * 2;
    #(limit_ns);
    $display("timeout: the run did not finish within %0d ns", limit_ns);
    $display("** FAIL **");
    $finish;
  end

  task automatic add_entry(input int cnt, input logic [7:0] b0, input logic [7:0] b1,
                           input logic [7:0] b2, input logic corrupt, input logic has_act,
                           input ray_pkg::key_action_e act);
    entry_t e;
    e.bytes   = {b2, b1, b0};
    e.count   = 2'(cnt);
    e.corrupt = corrupt;
    e.has_act = has_act;
    e.act     = act;
    stim.push_back(e);
  endtask

  task automatic add_key(input logic [7:0] sc, input ray_pkg::key_action_e act);
    add_entry(1, sc, 8'h00, 8'h00, 1'b0, 1'b1, act);
  endtask

  task automatic add_arrow(input logic [7:0] sc, input ray_pkg::key_action_e act);
    add_entry(2, ray_pkg::SC_EXT, sc, 8'h00, 1'b0, 1'b1, act);
  endtask

  task automatic build_table();
    // first ten entries hold each mapped key once
    add_key(ray_pkg::SC_W, ray_pkg::ACT_FORWARD);
    add_key(ray_pkg::SC_S, ray_pkg::ACT_BACK);
    add_key(ray_pkg::SC_A, ray_pkg::ACT_TURN_LEFT);
    add_key(ray_pkg::SC_D, ray_pkg::ACT_TURN_RIGHT);
    add_arrow(ray_pkg::SC_UP, ray_pkg::ACT_RISE);
    add_arrow(ray_pkg::SC_DOWN, ray_pkg::ACT_SINK);
    add_key(ray_pkg::SC_F, ray_pkg::ACT_FRACTAL_NEXT);
    add_key(ray_pkg::SC_H, ray_pkg::ACT_TOGGLE_HUE);
    add_key(ray_pkg::SC_J, ray_pkg::ACT_TOGGLE_DITHER);
    add_key(ray_pkg::SC_T, ray_pkg::ACT_TOGGLE_TEXTURE);
    add_key(ray_pkg::SC_W, ray_pkg::ACT_FORWARD);
    repeat (4) add_key(ray_pkg::SC_A, ray_pkg::ACT_TURN_LEFT);
    repeat (4) add_key(ray_pkg::SC_D, ray_pkg::ACT_TURN_RIGHT);
    add_key(ray_pkg::SC_A, ray_pkg::ACT_TURN_LEFT);
    add_key(ray_pkg::SC_W, ray_pkg::ACT_FORWARD);
    add_key(ray_pkg::SC_D, ray_pkg::ACT_TURN_RIGHT);
    repeat (5) add_key(ray_pkg::SC_F, ray_pkg::ACT_FRACTAL_NEXT);
    add_key(ray_pkg::SC_H, ray_pkg::ACT_TOGGLE_HUE);
    // releases and unknown codes
    add_entry(2, ray_pkg::SC_BREAK, ray_pkg::SC_W, 8'h00, 1'b0, 1'b0, ray_pkg::ACT_FORWARD);
    add_entry(3, ray_pkg::SC_EXT, ray_pkg::SC_BREAK, ray_pkg::SC_UP, 1'b0, 1'b0,
              ray_pkg::ACT_RISE);
    add_entry(1, 8'h15, 8'h00, 8'h00, 1'b0, 1'b0, ray_pkg::ACT_FORWARD);
    add_entry(2, ray_pkg::SC_EXT, ray_pkg::SC_W, 8'h00, 1'b0, 1'b0, ray_pkg::ACT_FORWARD);
    // bad parity, then a good key
    add_entry(1, ray_pkg::SC_W, 8'h00, 8'h00, 1'b1, 1'b0, ray_pkg::ACT_FORWARD);
    add_key(ray_pkg::SC_W, ray_pkg::ACT_FORWARD);
    add_entry(1, ray_pkg::SC_F, 8'h00, 8'h00, 1'b1, 1'b0, ray_pkg::ACT_FRACTAL_NEXT);
    add_key(ray_pkg::SC_J, ray_pkg::ACT_TOGGLE_DITHER);
    // climb until pos.y wraps negative
    repeat (130) add_arrow(ray_pkg::SC_UP, ray_pkg::ACT_RISE);
    add_key(ray_pkg::SC_S, ray_pkg::ACT_BACK);
    repeat (20) stim.push_back(stim[$urandom % 10]);
  endtask

  task automatic apply_action(input ray_pkg::key_action_e act);
    ray_pkg::coord_t old_x;
    old_x = model_dir.x;
    case (act)
      ray_pkg::ACT_FORWARD: begin
        model_pos.x += model_dir.x;
        model_pos.y += model_dir.y;
        model_pos.z += model_dir.z;
      end
      ray_pkg::ACT_BACK: begin
        model_pos.x -= model_dir.x;
        model_pos.y -= model_dir.y;
        model_pos.z -= model_dir.z;
      end
      ray_pkg::ACT_TURN_LEFT: begin
        model_dir.x = model_dir.z;
        model_dir.z = -old_x;
      end
      ray_pkg::ACT_TURN_RIGHT: begin
        model_dir.x = -model_dir.z;
        model_dir.z = old_x;
      end
      ray_pkg::ACT_RISE: model_pos.y += 16'sh0100;
      ray_pkg::ACT_SINK: model_pos.y -= 16'sh0100;
      ray_pkg::ACT_FRACTAL_NEXT: model_fractal = 3'((int'(model_fractal) + 1) % 5);
      ray_pkg::ACT_TOGGLE_HUE: model_hue = !model_hue;
      ray_pkg::ACT_TOGGLE_DITHER: model_dither = !model_dither;
      ray_pkg::ACT_TOGGLE_TEXTURE: model_texture = !model_texture;
      default: ;
    endcase
  endtask

  task automatic check_outputs();
    ray_pkg::vec3_t got_pos;
    ray_pkg::vec3_t got_dir;
    got_pos = '{x: pos_x, y: pos_y, z: pos_z};
    got_dir = '{x: dir_x, y: dir_y, z: dir_z};
    check_vec3("pos", got_pos, model_pos);
    check_vec3("dir", got_dir, model_dir);
    check_fractal("fractal_sel", fractal_sel, model_fractal);
    check_flag("toggle_hue", toggle_hue, model_hue);
    check_flag("toggle_dither", toggle_dither, model_dither);
    check_flag("toggle_texture", toggle_texture, model_texture);
    check_flag("frame_error", frame_error, 1'b0);
  endtask

  task automatic run_entry(input entry_t e);
    for (int b = 0; b < int'(e.count); b++) begin
      send_ps2_byte(e.bytes[b], e.corrupt && (b == int'(e.count) - 1));
    end
    if (e.corrupt) begin
      corrupt_sent++;
    end
    if (e.has_act) begin
      apply_action(e.act);
    end
    wait_cycles(8);
    check_outputs();
  endtask

  initial begin
    sys_rst  = 1'b1;
    ps2_clk  = 1'b1;
    ps2_data = 1'b1;
    void'($urandom(32'hc6f1_c962));
    build_table();
    table_ready   = 1'b1;
    model_pos     = '{x: 16'sh0000, y: 16'sh0000, z: 16'shfc00};
    model_dir     = '{x: 16'sh0000, y: 16'sh0000, z: 16'sh0100};
    model_fractal = 3'd0;
    model_hue     = 1'b0;
    model_dither  = 1'b0;
    model_texture = 1'b0;
    wait_cycles(10);
    sys_rst = 1'b0;
    wait_cycles(1);
    check_outputs();
    for (int n = 0; n < stim.size(); n++) begin
      run_entry(stim[n]);
    end
    if (frame_err_seen != corrupt_sent) begin
      $display("frame_error pulsed %0d times for %0d corrupt frames", frame_err_seen,
               corrupt_sent);
      mismatch_count++;
    end
    $display("errors: %0d mismatches, %0d frame_error pulses of %0d expected",
             mismatch_count, frame_err_seen, corrupt_sent);
    if (mismatch_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
